/* hdl/ls_pkg.sv */
package ls_pkg;

    localparam int unsigned DATA_W     = 32;      // Data and address width
    localparam int unsigned REG_ADDR_W = 5;       // Register index width
    localparam int unsigned BE_W       = 4;       // One enable per byte lane

    // Memory access opcodes handled by the load/store path
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_LB  = 4'd1,                            // Load byte, sign extended
        OP_LBU = 4'd2,                            // Load byte, zero extended
        OP_LH  = 4'd3,
        OP_LHU = 4'd4,
        OP_LW  = 4'd5,
        OP_LWL = 4'd6,                            // Unaligned left part
        OP_LWR = 4'd7,                            // Unaligned right part
        OP_LUI = 4'd8,                            // No bus access
        OP_SB  = 4'd9,
        OP_SH  = 4'd10,
        OP_SW  = 4'd11
    } ls_op_e;

    // One operation as issued by the core
    typedef struct packed {
        ls_op_e                  op;
        logic [REG_ADDR_W-1:0]   rt;              // Target register index
        logic [DATA_W-1:0]       rs_data;         // Base address register
        logic [DATA_W-1:0]       rt_data;         // Store data or merge source
        logic [15:0]             offset;          // Immediate
    } ls_req_t;

    // Access after address generation
    typedef struct packed {
        ls_op_e                  op;
        logic [REG_ADDR_W-1:0]   rt;
        logic [DATA_W-1:0]       rt_data;         // Kept for LWL/LWR merge
        logic [DATA_W-1:0]       word_addr;       // Low two bits cleared
        logic [1:0]              lane;            // Byte within the word
        logic [BE_W-1:0]         byteenable;
        logic [DATA_W-1:0]       writedata;       // Store data on its lanes
        logic [15:0]             imm;             // Needed for LUI
    } ls_acc_t;

    // Completed access with the captured memory word
    typedef struct packed {
        ls_acc_t                 acc;
        logic [DATA_W-1:0]       readdata;
    } ls_rsp_t;

    // Register file write
    typedef struct packed {
        logic [REG_ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]       data;
    } ls_wb_t;

endpackage

/* hdl/ls_addr_gen.sv */
`timescale 1ns/10ps

module ls_addr_gen (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            op_valid,
    input  ls_pkg::ls_req_t op_in,
    input  logic            stall,
    output logic            acc_valid,
    output ls_pkg::ls_acc_t acc
);

    logic [ls_pkg::DATA_W-1:0] offset_sext;
    logic [ls_pkg::DATA_W-1:0] eff_addr;
    logic [1:0]                lane;
    logic [ls_pkg::BE_W-1:0]   be;
    logic                      is_half;
    logic                      is_word;

    assign offset_sext = {{16{op_in.offset[15]}}, op_in.offset};
    assign eff_addr    = op_in.rs_data + offset_sext;
    assign lane        = eff_addr[1:0];

    assign is_half = (op_in.op == ls_pkg::OP_LH) || (op_in.op == ls_pkg::OP_LHU) ||
                     (op_in.op == ls_pkg::OP_SH);
    assign is_word = (op_in.op == ls_pkg::OP_LW) || (op_in.op == ls_pkg::OP_SW);

    always_comb begin
        case (op_in.op)
            ls_pkg::OP_LB, ls_pkg::OP_LBU, ls_pkg::OP_SB:
                be = ls_pkg::BE_W'(4'b0001 << lane);            // Single lane
            ls_pkg::OP_LH, ls_pkg::OP_LHU, ls_pkg::OP_SH:
                be = lane[1] ? 4'b1100 : 4'b0011;
            ls_pkg::OP_LW, ls_pkg::OP_SW:
                be = 4'b1111;
            ls_pkg::OP_LWL: begin                               // Lanes 0 up to lane
                case (lane)
                    2'd0:    be = 4'b0001;
                    2'd1:    be = 4'b0011;
                    2'd2:    be = 4'b0111;
                    default: be = 4'b1111;
                endcase
            end
            ls_pkg::OP_LWR:
                be = ls_pkg::BE_W'(4'b1111 << lane);            // Lane up to lane 3
            default:
                be = 4'b0000;                                   // LUI and NOP
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_valid <= 1'b0;
        end else if (!stall) begin
            acc_valid <= op_valid;                              // Bubble when idle
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && op_valid) begin
            acc.op         <= op_in.op;
            acc.rt         <= op_in.rt;
            acc.rt_data    <= op_in.rt_data;
            acc.word_addr  <= {eff_addr[ls_pkg::DATA_W-1:2], 2'b00};
            acc.lane       <= lane;
            acc.byteenable <= be;
            acc.writedata  <= op_in.rt_data << {lane, 3'b000};  // Move onto lanes
            acc.imm        <= op_in.offset;
        end
    end

    a_half_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        (op_valid && !stall && is_half) |-> (eff_addr[0] == 1'b0))
        else $error("Misaligned halfword access at %h", eff_addr);

    a_word_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        (op_valid && !stall && is_word) |-> (eff_addr[1:0] == 2'b00))
        else $error("Misaligned word access at %h", eff_addr);

endmodule

/* hdl/ls_mem_req.sv */
`timescale 1ns/10ps

module ls_mem_req (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      acc_valid,
    input  ls_pkg::ls_acc_t           acc,
    input  logic [ls_pkg::DATA_W-1:0] mem_readdata,
    input  logic                      waitrequest,
    output logic                      stall,
    output logic [ls_pkg::DATA_W-1:0] mem_address,
    output logic [ls_pkg::BE_W-1:0]   mem_byteenable,
    output logic [ls_pkg::DATA_W-1:0] mem_writedata,
    output logic                      mem_readenable,
    output logic                      mem_writeenable,
    output logic                      rsp_valid,
    output ls_pkg::ls_rsp_t           rsp
);

    logic is_read;
    logic is_write;
    logic bus_req;
    logic advance;

    // Which opcodes touch memory
    always_comb begin
        is_read  = 1'b0;
        is_write = 1'b0;
        case (acc.op)
            ls_pkg::OP_LB, ls_pkg::OP_LBU, ls_pkg::OP_LH, ls_pkg::OP_LHU,
            ls_pkg::OP_LW, ls_pkg::OP_LWL, ls_pkg::OP_LWR:
                is_read = 1'b1;
            ls_pkg::OP_SB, ls_pkg::OP_SH, ls_pkg::OP_SW:
                is_write = 1'b1;
            default: begin
                is_read  = 1'b0;                                // LUI and NOP skip the bus
                is_write = 1'b0;
            end
        endcase
    end

    // Request comes straight from the stage 1 register, which holds under stall
    assign mem_readenable  = acc_valid && is_read;
    assign mem_writeenable = acc_valid && is_write;
    assign mem_address     = acc.word_addr;
    assign mem_byteenable  = acc.byteenable;
    assign mem_writedata   = acc.writedata;

    assign bus_req = mem_readenable || mem_writeenable;
    assign stall   = bus_req && waitrequest;                    // Memory not ready yet
    assign advance = acc_valid && !stall;                       // Access completes now

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= advance;                               // Bubble while holding
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            rsp.acc      <= acc;
            rsp.readdata <= mem_readenable ? mem_readdata : '0;
        end
    end

    // Avalon rule: request must stay put until accepted
    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (bus_req && waitrequest) |=>
            ($stable(mem_address) && $stable(mem_byteenable) &&
             $stable(mem_readenable) && $stable(mem_writeenable)))
        else $error("Bus request changed under waitrequest");

endmodule

/* hdl/ls_load_align.sv */
`timescale 1ns/10ps

module ls_load_align (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            rsp_valid,
    input  ls_pkg::ls_rsp_t rsp,
    output logic            reg_writeenable,
    output ls_pkg::ls_wb_t  reg_wb
);

    logic [ls_pkg::DATA_W-1:0] rd;
    logic [ls_pkg::DATA_W-1:0] rt_old;
    logic [1:0]                lane;
    logic [7:0]                sel_byte;
    logic [15:0]               sel_half;
    logic [ls_pkg::DATA_W-1:0] wb_data;
    logic                      wb_en;
    logic                      is_store;

    assign rd     = rsp.readdata;
    assign rt_old = rsp.acc.rt_data;
    assign lane   = rsp.acc.lane;

    assign sel_byte = 8'(rd >> {lane, 3'b000});                 // Addressed byte
    assign sel_half = lane[1] ? rd[31:16] : rd[15:0];           // Addressed halfword

    assign is_store = (rsp.acc.op == ls_pkg::OP_SB) || (rsp.acc.op == ls_pkg::OP_SH) ||
                      (rsp.acc.op == ls_pkg::OP_SW);

    always_comb begin
        wb_en   = rsp_valid;
        wb_data = rd;
        case (rsp.acc.op)
            ls_pkg::OP_LB:
                wb_data = {{24{sel_byte[7]}}, sel_byte};
            ls_pkg::OP_LBU:
                wb_data = {24'h000000, sel_byte};
            ls_pkg::OP_LH:
                wb_data = {{16{sel_half[15]}}, sel_half};
            ls_pkg::OP_LHU:
                wb_data = {16'h0000, sel_half};
            ls_pkg::OP_LW:
                wb_data = rd;
            ls_pkg::OP_LUI:
                wb_data = {rsp.acc.imm, 16'h0000};
            ls_pkg::OP_LWL: begin
                // Low memory bytes go to the top of the register
                case (lane)
                    2'd0:    wb_data = {rd[7:0],  rt_old[23:0]};
                    2'd1:    wb_data = {rd[15:0], rt_old[15:0]};
                    2'd2:    wb_data = {rd[23:0], rt_old[7:0]};
                    default: wb_data = rd;
                endcase
            end
            ls_pkg::OP_LWR: begin
                // High memory bytes go to the bottom of the register
                case (lane)
                    2'd0:    wb_data = rd;
                    2'd1:    wb_data = {rt_old[31:24], rd[31:8]};
                    2'd2:    wb_data = {rt_old[31:16], rd[31:16]};
                    default: wb_data = {rt_old[31:8],  rd[31:24]};
                endcase
            end
            default:
                wb_en = 1'b0;                                   // Stores and NOP
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_writeenable <= 1'b0;
        end else begin
            reg_writeenable <= wb_en;                           // One pulse per load
        end
    end

    always_ff @(posedge clk) begin
        if (wb_en) begin
            reg_wb.addr <= rsp.acc.rt;
            reg_wb.data <= wb_data;
        end
    end

    a_no_store_wb: assert property (@(posedge clk) disable iff (!arst_n)
        (rsp_valid && is_store) |=> !reg_writeenable)
        else $error("Register write issued for a store");

endmodule

/* hdl/ls_top.sv */
`timescale 1ns/10ps

module ls_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      op_valid,
    input  ls_pkg::ls_req_t           op_in,
    output logic                      stall,
    output logic [ls_pkg::DATA_W-1:0] mem_address,
    output logic [ls_pkg::BE_W-1:0]   mem_byteenable,
    output logic [ls_pkg::DATA_W-1:0] mem_writedata,
    output logic                      mem_readenable,
    output logic                      mem_writeenable,
    input  logic [ls_pkg::DATA_W-1:0] mem_readdata,
    input  logic                      waitrequest,
    output logic                      reg_writeenable,
    output ls_pkg::ls_wb_t            reg_wb
);

    logic            acc_valid;
    ls_pkg::ls_acc_t acc;
    logic            rsp_valid;
    ls_pkg::ls_rsp_t rsp;

    ls_addr_gen i_addr_gen (                                    // Stage 1
        .clk       (clk),
        .arst_n    (arst_n),
        .op_valid  (op_valid),
        .op_in     (op_in),
        .stall     (stall),
        .acc_valid (acc_valid),
        .acc       (acc)
    );

    ls_mem_req i_mem_req (                                      // Stage 2
        .clk             (clk),
        .arst_n          (arst_n),
        .acc_valid       (acc_valid),
        .acc             (acc),
        .mem_readdata    (mem_readdata),
        .waitrequest     (waitrequest),
        .stall           (stall),
        .mem_address     (mem_address),
        .mem_byteenable  (mem_byteenable),
        .mem_writedata   (mem_writedata),
        .mem_readenable  (mem_readenable),
        .mem_writeenable (mem_writeenable),
        .rsp_valid       (rsp_valid),
        .rsp             (rsp)
    );

    ls_load_align i_load_align (                                // Stage 3
        .clk             (clk),
        .arst_n          (arst_n),
        .rsp_valid       (rsp_valid),
        .rsp             (rsp),
        .reg_writeenable (reg_writeenable),
        .reg_wb          (reg_wb)
    );

endmodule

/* test/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                                 // 20 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;                                         // Two cycles in reset
    end

endmodule

/* test/tb_mem_model.sv */
`timescale 1ns/10ps

module tb_mem_model (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        wait_en,
    input  logic [31:0] address,
    input  logic [3:0]  byteenable,
    input  logic [31:0] writedata,
    input  logic        readenable,
    input  logic        writeenable,
    output logic [31:0] readdata,
    output logic        waitrequest
);

    logic [31:0] mem [0:63];
    logic        wait_roll;
    logic [5:0]  idx;

    initial begin
        #1;                                                     // After the seed is set
        for (int i = 0; i < 64; i++) begin
            mem[i] = $urandom;
        end
    end

    assign idx         = address[7:2];
    assign readdata    = mem[idx];                              // Combinational read
    assign waitrequest = (readenable || writeenable) && wait_roll;

    // One roll per cycle, high about one time in three
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_roll <= 1'b0;
        end else begin
            wait_roll <= wait_en && ($urandom_range(0, 2) == 0);
        end
    end

    always @(posedge clk) begin
        if (writeenable && !waitrequest) begin
            for (int b = 0; b < 4; b++) begin
                if (byteenable[b]) begin
                    mem[idx][b*8 +: 8] <= writedata[b*8 +: 8];
                end
            end
        end
    end

endmodule

/* test/tb_ls_top.sv */
`timescale 1ns/10ps

module tb_ls_top;

    localparam int N_T2   = 14;
    localparam int N_T3   = 14;
    localparam int N_T4   = 10;
    localparam int N_T5   = 400;
    localparam int TIMEOUT_CYCLES = (N_T2 + N_T3 + N_T4 + N_T5) * 8 + 100;

    logic                   clk;
    logic                   arst_n;
    logic                   op_valid;
    ls_pkg::ls_req_t        op_in;
    logic                   stall;
    logic [31:0]            mem_address;
    logic [3:0]             mem_byteenable;
    logic [31:0]            mem_writedata;
    logic                   mem_readenable;
    logic                   mem_writeenable;
    logic [31:0]            mem_readdata;
    logic                   waitrequest;
    logic                   reg_writeenable;
    ls_pkg::ls_wb_t         reg_wb;
    logic                   wait_en;

    logic [31:0]            shadow [0:63];                  // Expected memory contents
    ls_pkg::ls_wb_t         exp_q [$];
    int                     edge_cnt = 0;
    int                     err_cnt = 0;
    int                     writes_checked = 0;
    int                     tests_pass = 0;
    int                     tests_fail = 0;
    int                     issue_stamp = 0;
    logic                   lat_check = 1'b0;
    logic                   idle_check = 1'b0;
    logic                   bus_check = 1'b0;

    tb_clk_gen i_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    tb_mem_model i_mem (
        .clk         (clk),
        .arst_n      (arst_n),
        .wait_en     (wait_en),
        .address     (mem_address),
        .byteenable  (mem_byteenable),
        .writedata   (mem_writedata),
        .readenable  (mem_readenable),
        .writeenable (mem_writeenable),
        .readdata    (mem_readdata),
        .waitrequest (waitrequest)
    );

    ls_top i_dut (
        .clk             (clk),
        .arst_n          (arst_n),
        .op_valid        (op_valid),
        .op_in           (op_in),
        .stall           (stall),
        .mem_address     (mem_address),
        .mem_byteenable  (mem_byteenable),
        .mem_writedata   (mem_writedata),
        .mem_readenable  (mem_readenable),
        .mem_writeenable (mem_writeenable),
        .mem_readdata    (mem_readdata),
        .waitrequest     (waitrequest),
        .reg_writeenable (reg_writeenable),
        .reg_wb          (reg_wb)
    );

    // Expected register value for a load or LUI
    function automatic logic [31:0] ref_load(input ls_pkg::ls_op_e op, input logic [1:0] lane,
                                             input logic [31:0] word, input logic [31:0] rt_data,
                                             input logic [15:0] imm);
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] r;
        b = word[lane*8 +: 8];
        h = word[lane[1]*16 +: 16];
        r = rt_data;
        case (op)
            ls_pkg::OP_LB:  r = {{24{b[7]}}, b};
            ls_pkg::OP_LBU: r = {24'h0, b};
            ls_pkg::OP_LH:  r = {{16{h[15]}}, h};
            ls_pkg::OP_LHU: r = {16'h0, h};
            ls_pkg::OP_LW:  r = word;
            ls_pkg::OP_LUI: r = {imm, 16'h0};
            ls_pkg::OP_LWL: begin
                for (int k = 0; k <= lane; k++) begin
                    r[(3 - lane + k)*8 +: 8] = word[k*8 +: 8];  // Low bytes to the top
                end
            end
            ls_pkg::OP_LWR: begin
                for (int k = lane; k < 4; k++) begin
                    r[(k - lane)*8 +: 8] = word[k*8 +: 8];      // High bytes to the bottom
                end
            end
            default: r = rt_data;
        endcase
        return r;
    endfunction

    task automatic build_req(input ls_pkg::ls_op_e op, input logic [7:0] ea,
                             input logic [4:0] rt, input logic [31:0] rt_data,
                             output ls_pkg::ls_req_t req);
        logic [15:0] off;
        off         = 16'($urandom);
        req.op      = op;
        req.rt      = rt;
        req.rt_data = rt_data;
        req.offset  = off;
        req.rs_data = {24'h0, ea} - {{16{off[15]}}, off};      // Base so that ea lands in range
    endtask

    // Stage 1 has taken the op, so update the model
    task automatic accept(input ls_pkg::ls_req_t req);
        logic [31:0]    ea;
        logic [5:0]     idx;
        ls_pkg::ls_wb_t wb;
        ea  = req.rs_data + {{16{req.offset[15]}}, req.offset};
        idx = ea[7:2];
        case (req.op)
            ls_pkg::OP_SB:  shadow[idx][ea[1:0]*8 +: 8]  = req.rt_data[7:0];
            ls_pkg::OP_SH:  shadow[idx][ea[1:0]*8 +: 16] = req.rt_data[15:0];
            ls_pkg::OP_SW:  shadow[idx] = req.rt_data;
            ls_pkg::OP_NOP: begin
                // No memory change and no register write
            end
            default: begin
                wb.addr = req.rt;
                wb.data = ref_load(req.op, ea[1:0], shadow[idx], req.rt_data, req.offset);
                exp_q.push_back(wb);
            end
        endcase
    endtask

    task automatic issue(input ls_pkg::ls_req_t req);
        op_valid    <= 1'b1;
        op_in       <= req;
        issue_stamp = edge_cnt;
        @(posedge clk);
        while (stall) begin
            @(posedge clk);                                     // Held until stage 1 takes it
        end
        accept(req);
    endtask

    task automatic idle(input int n);
        op_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic drain();
        op_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic run_single(input ls_pkg::ls_op_e op, input logic [7:0] ea,
                              input logic [31:0] rt_data);
        ls_pkg::ls_req_t req;
        build_req(op, ea, 5'($urandom_range(0, 31)), rt_data, req);
        issue(req);
        drain();
    endtask

    task automatic random_req(output ls_pkg::ls_req_t req);
        ls_pkg::ls_op_e op;
        logic [7:0]     ea;
        op = ls_pkg::ls_op_e'($urandom_range(0, 11));
        ea = 8'($urandom_range(0, 255));
        if (op == ls_pkg::OP_LH || op == ls_pkg::OP_LHU || op == ls_pkg::OP_SH) begin
            ea[0] = 1'b0;
        end
        if (op == ls_pkg::OP_LW || op == ls_pkg::OP_SW) begin
            ea[1:0] = 2'b00;
        end
        build_req(op, ea, 5'($urandom_range(0, 31)), $urandom, req);
    endtask

    task automatic end_test(input string name, input int err_before);
        if (err_cnt == err_before) begin
            tests_pass++;
            $display("Test %s: pass", name);
        end else begin
            tests_fail++;
            $display("Test %s: fail with %0d errors", name, err_cnt - err_before);
        end
    endtask

    // Compare each register write with the oldest expected one
    always @(posedge clk) begin
        ls_pkg::ls_wb_t exp;
        if (arst_n && reg_writeenable) begin
            if (exp_q.size() == 0) begin
                $display("Register write to r%0d at %0t with no load pending",
                         reg_wb.addr, $time);
                err_cnt++;
            end else begin
                exp = exp_q.pop_front();
                writes_checked++;
                if (reg_wb.addr !== exp.addr) begin
                    $display("FAIL t=%0t reg_wb.addr expected %0d got %0d",
                             $time, exp.addr, reg_wb.addr);
                    err_cnt++;
                end
                if (reg_wb.data !== exp.data) begin
                    $display("FAIL t=%0t reg_wb.data expected %08h got %08h",
                             $time, exp.data, reg_wb.data);
                    err_cnt++;
                end
                // Pulse is seen one edge after it is set
                if (lat_check && (edge_cnt != issue_stamp + 4)) begin
                    $display("FAIL t=%0t reg_writeenable latency expected %0d got %0d",
                             $time, 3, edge_cnt - issue_stamp - 1);
                    err_cnt++;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (idle_check && (reg_writeenable || mem_readenable || mem_writeenable || stall)) begin
            $display("Outputs not idle after reset at %0t", $time);
            err_cnt++;
        end
        if (bus_check && (mem_readenable || mem_writeenable)) begin
            $display("Bus request seen during LUI at %0t", $time);
            err_cnt++;
        end
    end

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
        if (edge_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, operations did not complete", edge_cnt);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        ls_pkg::ls_req_t req;
        int              err_before;
        logic [5:0]      w;
        void'($urandom(92310));
        op_valid = 1'b0;
        op_in    = '0;
        wait_en  = 1'b0;
        wait (arst_n);
        @(posedge clk);
        for (int i = 0; i < 64; i++) begin
            shadow[i] = i_mem.mem[i];                           // Start from the preset image
        end

        err_before = err_cnt;
        idle_check = 1'b1;
        idle(10);
        idle_check = 1'b0;
        end_test("reset_idle", err_before);

        err_before = err_cnt;
        w = 6'($urandom_range(0, 63));
        run_single(ls_pkg::OP_SW, {w, 2'b00}, 32'h8A7F_F501);  // Mixed sign bits per lane
        lat_check = 1'b1;
        for (int l = 0; l < 4; l++) begin
            run_single(ls_pkg::OP_LB, 8'({w, 2'b00} + l), $urandom);
            run_single(ls_pkg::OP_LBU, 8'({w, 2'b00} + l), $urandom);
        end
        for (int l = 0; l < 4; l += 2) begin
            run_single(ls_pkg::OP_LH, 8'({w, 2'b00} + l), $urandom);
            run_single(ls_pkg::OP_LHU, 8'({w, 2'b00} + l), $urandom);
        end
        run_single(ls_pkg::OP_LW, {w, 2'b00}, $urandom);
        lat_check = 1'b0;
        end_test("loads_latency", err_before);

        err_before = err_cnt;
        wait_en <= 1'b1;
        w = 6'($urandom_range(0, 63));
        for (int l = 0; l < 4; l++) begin
            run_single(ls_pkg::OP_SB, 8'({w, 2'b00} + l), $urandom);
            run_single(ls_pkg::OP_LW, {w, 2'b00}, $urandom);
        end
        for (int l = 0; l < 4; l += 2) begin
            run_single(ls_pkg::OP_SH, 8'({w, 2'b00} + l), $urandom);
            run_single(ls_pkg::OP_LW, {w, 2'b00}, $urandom);
        end
        run_single(ls_pkg::OP_SW, {w, 2'b00}, $urandom);
        run_single(ls_pkg::OP_LW, {w, 2'b00}, $urandom);
        end_test("stores_readback", err_before);

        err_before = err_cnt;
        bus_check = 1'b1;
        run_single(ls_pkg::OP_LUI, 8'($urandom), $urandom);
        run_single(ls_pkg::OP_LUI, 8'($urandom), $urandom);
        bus_check = 1'b0;
        w = 6'($urandom_range(0, 63));
        for (int l = 0; l < 4; l++) begin
            build_req(ls_pkg::OP_LWL, 8'({w, 2'b00} + l), 5'(l), $urandom, req);
            issue(req);
            build_req(ls_pkg::OP_LWR, 8'({w, 2'b00} + l), 5'(l + 8), $urandom, req);
            issue(req);
        end
        drain();
        end_test("lwl_lwr_lui", err_before);

        err_before = err_cnt;
        for (int n = 0; n < N_T5; n++) begin
            random_req(req);
            issue(req);
            if ($urandom_range(0, 3) == 0) begin
                idle($urandom_range(1, 3));                     // Occasional gap
            end
        end
        drain();
        end_test("random_mix", err_before);

        $display("Tests: %0d passed, %0d failed, %0d writes checked, %0d errors",
                 tests_pass, tests_fail, writes_checked, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* ls_path.f */
hdl/ls_pkg.sv
hdl/ls_addr_gen.sv
hdl/ls_mem_req.sv
hdl/ls_load_align.sv
hdl/ls_top.sv
test/tb_clk_gen.sv
test/tb_mem_model.sv
test/tb_ls_top.sv
